//--- hw/core_pkg.sv
// Core data-memory package
// Access direction and size encodings, request and response structs

package core_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Direction of a data access
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_dir_e;

    // Access size, encoded like the RV32 load/store funct3 field
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } mem_size_e;

    // Request to the data SRAM, 69 bits
    typedef struct packed {
        logic [XLEN-1:0]     addr;   // Word aligned
        logic                write;
        logic [XLEN-1:0]     wdata;
        logic [XLEN/8-1:0]   wstrb;
    } dmem_req_t;

    // Response from the data SRAM
    // Don't-care data for writes
    typedef struct packed {
        logic [XLEN-1:0]     rdata;
    } dmem_rsp_t;

endpackage

//--- hw/core_stage_mem.sv
// Core load/store stage
// Aligns requests, steers store lanes and strobes, extends load data
`timescale 1ns/1ps

module core_stage_mem (
    input  logic                      clk,
    input  logic                      rst_n,
    // Core side
    input  logic                      mem_stage_valid,
    output logic                      mem_stage_ready,
    input  logic [core_pkg::XLEN-1:0] mem_addr,
    input  logic [core_pkg::XLEN-1:0] mem_wdata,
    input  core_pkg::mem_dir_e        mem_dir,
    input  core_pkg::mem_size_e       mem_size,
    output logic                      mem_rsp_valid,
    output logic [core_pkg::XLEN-1:0] mem_rdata,
    // Data memory side
    output logic                      dmem_valid,
    input  logic                      dmem_ready,
    output core_pkg::dmem_req_t       dmem_req,
    input  logic                      dmem_rsp_valid,
    input  core_pkg::dmem_rsp_t       dmem_rsp
);

    import core_pkg::*;

    logic        accept;
    logic [3:0]  lane_strb;
    logic [31:0] lane_wdata;
    mem_size_e   rsp_size_q;
    logic [1:0]  rsp_off_q;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    // Request goes straight through to the arbiter
    assign dmem_valid      = mem_stage_valid;
    assign mem_stage_ready = dmem_ready;
    assign accept          = mem_stage_valid & dmem_ready;

    // Put store data on the lanes picked by the low address bits
    always_comb begin
        case (mem_size)
            SIZE_B, SIZE_BU: begin
                lane_wdata = {4{mem_wdata[7:0]}};
                lane_strb  = 4'b0001 << mem_addr[1:0];
            end
            SIZE_H, SIZE_HU: begin
                lane_wdata = {2{mem_wdata[15:0]}};
                lane_strb  = mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_wdata = mem_wdata;
                lane_strb  = 4'b1111;
            end
        endcase
    end

    always_comb begin
        dmem_req.addr  = {mem_addr[XLEN-1:2], 2'b00};
        dmem_req.write = (mem_dir == MEM_WRITE);
        dmem_req.wdata = lane_wdata;
        // Loads carry no strobes
        dmem_req.wstrb = (mem_dir == MEM_WRITE) ? lane_strb : 4'b0000;
    end

    // Remember how to decode the response that comes back next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_size_q <= SIZE_W;
            rsp_off_q  <= 2'b00;
        end else if (accept) begin
            rsp_size_q <= mem_size;
            rsp_off_q  <= mem_addr[1:0];
        end
    end

    // Pick the addressed byte and half from the returned word
    always_comb begin
        case (rsp_off_q)
            2'd0:    rd_byte = dmem_rsp.rdata[7:0];
            2'd1:    rd_byte = dmem_rsp.rdata[15:8];
            2'd2:    rd_byte = dmem_rsp.rdata[23:16];
            default: rd_byte = dmem_rsp.rdata[31:24];
        endcase
        rd_half = rsp_off_q[1] ? dmem_rsp.rdata[31:16] : dmem_rsp.rdata[15:0];
    end

    // Sign or zero extension
    always_comb begin
        case (rsp_size_q)
            SIZE_B:  mem_rdata = {{24{rd_byte[7]}}, rd_byte};
            SIZE_BU: mem_rdata = {24'b0, rd_byte};
            SIZE_H:  mem_rdata = {{16{rd_half[15]}}, rd_half};
            SIZE_HU: mem_rdata = {16'b0, rd_half};
            default: mem_rdata = dmem_rsp.rdata;
        endcase
    end

    assign mem_rsp_valid = dmem_rsp_valid;

endmodule

//--- hw/host_mem_port.sv
// Host memory access port
// Whole-word accesses held in a one-entry buffer until granted
`timescale 1ns/1ps

module host_mem_port (
    input  logic                      clk,
    input  logic                      rst_n,
    // Host side
    input  logic                      host_req_valid,
    output logic                      host_req_ready,
    input  logic [core_pkg::XLEN-1:0] host_addr,
    input  logic [core_pkg::XLEN-1:0] host_wdata,
    input  logic                      host_write,
    output logic                      host_rsp_valid,
    output logic [core_pkg::XLEN-1:0] host_rdata,
    // Data memory side
    output logic                      dmem_valid,
    input  logic                      dmem_ready,
    output core_pkg::dmem_req_t       dmem_req,
    input  logic                      dmem_rsp_valid,
    input  core_pkg::dmem_rsp_t       dmem_rsp
);

    import core_pkg::*;

    logic      buf_valid_q;
    dmem_req_t buf_req_q;

    // Only take a new request once the previous one is granted
    assign host_req_ready = ~buf_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid_q <= 1'b0;
        end else if (host_req_valid && host_req_ready) begin
            buf_valid_q <= 1'b1;
        end else if (dmem_ready) begin
            buf_valid_q <= 1'b0;
        end
    end

    // Full word, all lanes
    always_ff @(posedge clk) begin
        if (host_req_valid && host_req_ready) begin
            buf_req_q.addr  <= {host_addr[XLEN-1:2], 2'b00};
            buf_req_q.write <= host_write;
            buf_req_q.wdata <= host_wdata;
            buf_req_q.wstrb <= '1;
        end
    end

    assign dmem_valid = buf_valid_q;
    assign dmem_req   = buf_req_q;

    assign host_rsp_valid = dmem_rsp_valid;
    assign host_rdata     = dmem_rsp.rdata;

endmodule

//--- hw/dmem_arbiter.sv
// Round-robin arbiter for the core and host in front of the data SRAM
// Tracks the owner of each accepted request to steer its response
`timescale 1ns/1ps

module dmem_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    // Core requester
    input  logic                core_valid,
    output logic                core_ready,
    input  core_pkg::dmem_req_t core_req,
    output logic                core_rsp_valid,
    // Host requester
    input  logic                host_valid,
    output logic                host_ready,
    input  core_pkg::dmem_req_t host_req,
    output logic                host_rsp_valid,
    // SRAM side
    output logic                sram_req_valid,
    output core_pkg::dmem_req_t sram_req
);

    logic last_host_q;
    logic core_grant;
    logic host_grant;
    logic core_rsp_q;
    logic host_rsp_q;

    // On a tie the side that did not win last time goes first
    assign core_ready = ~host_valid | last_host_q;
    assign host_ready = ~core_valid | ~last_host_q;

    assign core_grant = core_valid & core_ready;
    assign host_grant = host_valid & host_ready;

    assign sram_req_valid = core_grant | host_grant;
    assign sram_req       = host_grant ? host_req : core_req;

    // Last winner, starts as host so the core gets the first tie
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_host_q <= 1'b1;
        end else if (core_grant || host_grant) begin
            last_host_q <= host_grant;
        end
    end

    // Owner of the request now in the SRAM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_rsp_q <= 1'b0;
            host_rsp_q <= 1'b0;
        end else begin
            core_rsp_q <= core_grant;
            host_rsp_q <= host_grant;
        end
    end

    assign core_rsp_valid = core_rsp_q;
    assign host_rsp_valid = host_rsp_q;

endmodule

//--- hw/dmem_sram.sv
// Word-wide data SRAM
// Byte write strobes and a registered read port with one cycle of latency
`timescale 1ns/1ps

module dmem_sram #(
    parameter int MEM_DEPTH_WORDS = 1024
) (
    input  logic                clk,
    input  logic                sram_req_valid,
    input  core_pkg::dmem_req_t sram_req,
    output core_pkg::dmem_rsp_t sram_rsp
);

    import core_pkg::*;

    localparam int IDX_W = $clog2(MEM_DEPTH_WORDS);

    logic [XLEN-1:0]  mem [MEM_DEPTH_WORDS];
    logic [XLEN-1:0]  rdata_q;
    logic [IDX_W-1:0] word_idx;

    // Byte address to word index, wraps at the array depth
    assign word_idx = sram_req.addr[IDX_W+1:2];

    // Masked byte writes
    always_ff @(posedge clk) begin
        if (sram_req_valid && sram_req.write) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (sram_req.wstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= sram_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read port, old data on a write
    always_ff @(posedge clk) begin
        if (sram_req_valid) begin
            rdata_q <= mem[word_idx];
        end
    end

    assign sram_rsp.rdata = rdata_q;

endmodule

//--- hw/mem_subsys_top.sv
// Data-memory subsystem top
// Load/store stage and host port sharing one SRAM through the arbiter
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int MEM_DEPTH_WORDS = 1024
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // Core side
    input  logic                      mem_stage_valid,
    output logic                      mem_stage_ready,
    input  logic [core_pkg::XLEN-1:0] mem_addr,
    input  logic [core_pkg::XLEN-1:0] mem_wdata,
    input  core_pkg::mem_dir_e        mem_dir,
    input  core_pkg::mem_size_e       mem_size,
    output logic                      mem_rsp_valid,
    output logic [core_pkg::XLEN-1:0] mem_rdata,
    // Host side
    input  logic                      host_req_valid,
    output logic                      host_req_ready,
    input  logic [core_pkg::XLEN-1:0] host_addr,
    input  logic [core_pkg::XLEN-1:0] host_wdata,
    input  logic                      host_write,
    output logic                      host_rsp_valid,
    output logic [core_pkg::XLEN-1:0] host_rdata
);

    import core_pkg::*;

    logic      core_valid;
    logic      core_ready;
    dmem_req_t core_req;
    logic      core_rsp_valid;
    logic      host_valid;
    logic      host_ready;
    dmem_req_t host_req;
    logic      host_dmem_rsp_valid;
    logic      sram_req_valid;
    dmem_req_t sram_req;
    dmem_rsp_t sram_rsp;

    core_stage_mem u_stage_mem (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_stage_valid (mem_stage_valid),
        .mem_stage_ready (mem_stage_ready),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_dir         (mem_dir),
        .mem_size        (mem_size),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rdata       (mem_rdata),
        .dmem_valid      (core_valid),
        .dmem_ready      (core_ready),
        .dmem_req        (core_req),
        .dmem_rsp_valid  (core_rsp_valid),
        .dmem_rsp        (sram_rsp)
    );

    host_mem_port u_host_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready),
        .host_addr      (host_addr),
        .host_wdata     (host_wdata),
        .host_write     (host_write),
        .host_rsp_valid (host_rsp_valid),
        .host_rdata     (host_rdata),
        .dmem_valid     (host_valid),
        .dmem_ready     (host_ready),
        .dmem_req       (host_req),
        .dmem_rsp_valid (host_dmem_rsp_valid),
        .dmem_rsp       (sram_rsp)
    );

    dmem_arbiter u_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_valid     (core_valid),
        .core_ready     (core_ready),
        .core_req       (core_req),
        .core_rsp_valid (core_rsp_valid),
        .host_valid     (host_valid),
        .host_ready     (host_ready),
        .host_req       (host_req),
        .host_rsp_valid (host_dmem_rsp_valid),
        .sram_req_valid (sram_req_valid),
        .sram_req       (sram_req)
    );

    dmem_sram #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
    ) u_sram (
        .clk            (clk),
        .sram_req_valid (sram_req_valid),
        .sram_req       (sram_req),
        .sram_rsp       (sram_rsp)
    );

endmodule

//--- sim/mem_subsys_checker.sv
// Arbiter and SRAM interface assertions
// One grant per cycle, aligned addresses, response timing, stable stalled requests
`timescale 1ns/1ps

module mem_subsys_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                core_valid,
    input logic                core_ready,
    input core_pkg::dmem_req_t core_req,
    input logic                core_rsp_valid,
    input logic                host_valid,
    input logic                host_ready,
    input core_pkg::dmem_req_t host_req,
    input logic                host_rsp_valid,
    input logic                sram_req_valid,
    input core_pkg::dmem_req_t sram_req
);

    logic core_grant;
    logic host_grant;

    assign core_grant = core_valid & core_ready;
    assign host_grant = host_valid & host_ready;

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(core_grant && host_grant))
        else $error("Both requesters granted in the same cycle");

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        sram_req_valid |-> (sram_req.addr[1:0] == 2'b00))
        else $error("SRAM address is not word aligned");

    a_core_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        core_rsp_valid == $past(core_grant))
        else $error("Core response not one cycle after its grant");

    a_host_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        host_rsp_valid == $past(host_grant))
        else $error("Host response not one cycle after its grant");

    // Stalled requests stay put until granted
    a_core_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (core_valid && !core_ready) |=> (core_valid && $stable(core_req)))
        else $error("Stalled core request changed");

    a_host_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (host_valid && !host_ready) |=> (host_valid && $stable(host_req)))
        else $error("Stalled host request changed");

endmodule

bind dmem_arbiter mem_subsys_checker u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_valid     (core_valid),
    .core_ready     (core_ready),
    .core_req       (core_req),
    .core_rsp_valid (core_rsp_valid),
    .host_valid     (host_valid),
    .host_ready     (host_ready),
    .host_req       (host_req),
    .host_rsp_valid (host_rsp_valid),
    .sram_req_valid (sram_req_valid),
    .sram_req       (sram_req)
);

//--- sim/tb_mem_subsys.sv
// Directed testbench for the data-memory subsystem
// Byte-array reference model, response monitors and six directed tests
`timescale 1ns/1ps

module tb_mem_subsys;

    import core_pkg::*;

    localparam int DEPTH       = 256;
    localparam int BYTE_AW     = $clog2(DEPTH * 4);
    // Ops per test are 8 + 18 + 28 + 16 + 6 + 48
    localparam int NUM_OPS     = 124;
    localparam int CYCLE_LIMIT = NUM_OPS * 20;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            mem_stage_valid;
    logic            mem_stage_ready;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    mem_dir_e        mem_dir;
    mem_size_e       mem_size;
    logic            mem_rsp_valid;
    logic [XLEN-1:0] mem_rdata;
    logic            host_req_valid;
    logic            host_req_ready;
    logic [XLEN-1:0] host_addr;
    logic [XLEN-1:0] host_wdata;
    logic            host_write;
    logic            host_rsp_valid;
    logic [XLEN-1:0] host_rdata;

    logic [7:0]      ref_mem [DEPTH*4];
    logic [15:0]     lfsr_state = 16'd56095;
    int              cycle_cnt = 0;
    string           test_name = "reset";
    logic            core_acc_q;
    logic [XLEN-1:0] core_exp_q [$];
    bit              core_load_q [$];
    logic [XLEN-1:0] core_exp;
    dmem_rsp_t       host_exp_q [$];
    bit              host_read_q [$];
    dmem_rsp_t       host_exp;
    dmem_rsp_t       host_got;

    mem_subsys_top #(
        .MEM_DEPTH_WORDS (DEPTH)
    ) u_mem_subsys_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_stage_valid (mem_stage_valid),
        .mem_stage_ready (mem_stage_ready),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_dir         (mem_dir),
        .mem_size        (mem_size),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rdata       (mem_rdata),
        .host_req_valid  (host_req_valid),
        .host_req_ready  (host_req_ready),
        .host_addr       (host_addr),
        .host_wdata      (host_wdata),
        .host_write      (host_write),
        .host_rsp_valid  (host_rsp_valid),
        .host_rdata      (host_rdata)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_word(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_rsp(input dmem_rsp_t exp, input dmem_rsp_t act);
        if (act.rdata !== exp.rdata) begin
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h",
                               test_name, exp.rdata, act.rdata));
        end
    endtask

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [XLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return {addr[15:0] ^ 16'hA5C3, ~addr[15:0]} ^ {addr[31:16], addr[31:16]};
    endfunction

    // Byte-addressed reference model that wraps at the memory size
    function automatic logic [7:0] ref_byte(input logic [XLEN-1:0] addr);
        return ref_mem[addr[BYTE_AW-1:0]];
    endfunction

    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] addr,
                                                   input mem_size_e size);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_byte(addr);
        h = {ref_byte({addr[XLEN-1:1], 1'b1}), ref_byte({addr[XLEN-1:1], 1'b0})};
        case (size)
            SIZE_B:  return {{24{b[7]}}, b};
            SIZE_BU: return {24'h0, b};
            SIZE_H:  return {{16{h[15]}}, h};
            SIZE_HU: return {16'h0, h};
            default: return {ref_byte({addr[XLEN-1:2], 2'd3}), ref_byte({addr[XLEN-1:2], 2'd2}),
                             ref_byte({addr[XLEN-1:2], 2'd1}), ref_byte({addr[XLEN-1:2], 2'd0})};
        endcase
    endfunction

    function automatic void ref_store(input logic [XLEN-1:0] addr, input mem_size_e size,
                                      input logic [XLEN-1:0] data);
        case (size)
            SIZE_B, SIZE_BU: ref_mem[addr[BYTE_AW-1:0]] = data[7:0];
            SIZE_H, SIZE_HU: begin
                ref_mem[{addr[BYTE_AW-1:1], 1'b0}] = data[7:0];
                ref_mem[{addr[BYTE_AW-1:1], 1'b1}] = data[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[{addr[BYTE_AW-1:2], 2'(k)}] = data[8*k +: 8];
                end
            end
        endcase
    endfunction

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            fail_run("Run exceeded the global cycle limit");
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_acc_q <= 1'b0;
        end else begin
            core_acc_q <= mem_stage_valid & mem_stage_ready;
        end
    end

    // Core responses checked in the middle of the response cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_rsp_valid !== core_acc_q) begin
                fail_run("Core response did not come exactly one cycle after acceptance");
            end else if (mem_rsp_valid) begin
                core_exp = core_exp_q.pop_front();
                if (core_load_q.pop_front()) begin
                    check_word(core_exp, mem_rdata);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && host_rsp_valid) begin
            if (host_exp_q.size() == 0) begin
                fail_run("Host response arrived with no request outstanding");
            end else begin
                host_got.rdata = host_rdata;
                host_exp = host_exp_q.pop_front();
                if (host_read_q.pop_front()) begin
                    check_rsp(host_exp, host_got);
                end
            end
        end
    end

    // Issue one core access; returns after the accepting edge
    task automatic core_op(input mem_dir_e dir, input mem_size_e size,
                           input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                           output int acc_cyc);
        int waited;
        waited = 0;
        @(negedge clk);
        mem_stage_valid = 1'b1;
        mem_dir   = dir;
        mem_size  = size;
        mem_addr  = addr;
        mem_wdata = wdata;
        #1;
        while (!mem_stage_ready && waited < 20) begin
            waited++;
            @(negedge clk);
            #1;
        end
        if (!mem_stage_ready) begin
            fail_run("Core request was not accepted within 20 cycles");
        end else begin
            acc_cyc = cycle_cnt;
            @(posedge clk);
            if (dir == MEM_WRITE) begin
                ref_store(addr, size, wdata);
            end
            core_exp_q.push_back(load_value(addr, size));
            core_load_q.push_back(dir == MEM_READ);
        end
    endtask

    task automatic core_release();
        @(negedge clk);
        mem_stage_valid = 1'b0;
    endtask

    task automatic host_op(input logic wr, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] wdata);
        int        waited;
        dmem_rsp_t exp;
        waited = 0;
        @(negedge clk);
        host_req_valid = 1'b1;
        host_write = wr;
        host_addr  = addr;
        host_wdata = wdata;
        #1;
        while (!host_req_ready && waited < 20) begin
            waited++;
            @(negedge clk);
            #1;
        end
        if (!host_req_ready) begin
            fail_run("Host request was not accepted within 20 cycles");
        end else begin
            @(posedge clk);
            if (wr) begin
                ref_store(addr, SIZE_W, wdata);
            end
            exp.rdata = load_value(addr, SIZE_W);
            host_exp_q.push_back(exp);
            host_read_q.push_back(!wr);
            @(negedge clk);
            host_req_valid = 1'b0;
        end
    endtask

    // Stop issuing and wait for every outstanding response
    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        mem_stage_valid = 1'b0;
        host_req_valid  = 1'b0;
        #1;
        while ((core_exp_q.size() != 0 || host_exp_q.size() != 0) && waited < 20) begin
            waited++;
            @(negedge clk);
            #1;
        end
        if (core_exp_q.size() != 0 || host_exp_q.size() != 0) begin
            fail_run("A response did not arrive within 20 cycles");
        end
    endtask

    task automatic write_read_words();
        logic [XLEN-1:0] addrs [4] = '{32'h0C, 32'h191, 32'h320, 32'h7F8};
        test_name = "host_rw";
        foreach (addrs[i]) host_op(1'b1, addrs[i], fill_word(addrs[i]));
        foreach (addrs[i]) host_op(1'b0, addrs[i], '0);
        drain();
    endtask

    task automatic store_lanes();
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] off;
        int              c;
        test_name = "store_lanes";
        for (int i = 0; i < 6; i++) begin
            off = (i < 4) ? 32'(i) : 32'((i - 4) * 2);
            take_bits(32, d);
            host_op(1'b1, 32'h60, fill_word(32'h60 + 32'(i)));
            core_op(MEM_WRITE, (i < 4) ? SIZE_B : SIZE_H, 32'h60 + off, d, c);
            drain();
            host_op(1'b0, 32'h60, '0);
            drain();
        end
    endtask

    task automatic load_extend();
        mem_size_e sizes [5] = '{SIZE_B, SIZE_BU, SIZE_H, SIZE_HU, SIZE_W};
        int        step;
        int        c;
        test_name = "load_extend";
        host_op(1'b1, 32'h40, 32'h80FF_7F01);
        host_op(1'b1, 32'h44, 32'h7F00_80FE);
        drain();
        for (int w = 0; w < 2; w++) begin
            foreach (sizes[s]) begin
                step = (s < 2) ? 1 : ((s < 4) ? 2 : 4);
                for (int off = 0; off < 4; off += step) begin
                    core_op(MEM_READ, sizes[s], 32'h40 + 32'(w * 4 + off), '0, c);
                end
            end
        end
        drain();
    endtask

    task automatic contend_ports();
        int c;
        test_name = "contention";
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    core_op(MEM_WRITE, SIZE_W, 32'h80 + 32'(i * 4), fill_word(32'h80 + 32'(i)), c);
                end
                for (int i = 0; i < 4; i++) begin
                    core_op(MEM_READ, SIZE_W, 32'h80 + 32'(i * 4), '0, c);
                end
                core_release();
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    host_op(1'b1, 32'hA0 + 32'(i * 4), fill_word(32'hA0 + 32'(i)));
                end
                for (int i = 0; i < 4; i++) begin
                    host_op(1'b0, 32'hA0 + 32'(i * 4), '0);
                end
            end
        join
        drain();
    endtask

    task automatic loads_back_to_back();
        logic [XLEN-1:0] addrs [6] = '{32'h0C, 32'h190, 32'h323, 32'h7F8, 32'h0E, 32'h192};
        mem_size_e       sizes [6] = '{SIZE_W, SIZE_B, SIZE_BU, SIZE_H, SIZE_HU, SIZE_W};
        int              first;
        int              c;
        test_name = "back_to_back";
        first = 0;
        foreach (addrs[i]) begin
            core_op(MEM_READ, sizes[i], addrs[i], '0, c);
            if (i == 0) first = c;
        end
        drain();
        if (c - first != 5) begin
            fail_run("Back-to-back core loads were not accepted on consecutive cycles");
        end
    endtask

    task automatic random_traffic();
        mem_size_e       sizes [5] = '{SIZE_B, SIZE_BU, SIZE_H, SIZE_HU, SIZE_W};
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] off;
        logic [XLEN-1:0] data;
        int              sel;
        int              c;
        test_name = "random";
        for (int i = 0; i < 8; i++) begin
            host_op(1'b1, 32'h100 + 32'(i * 4), fill_word(32'h100 + 32'(i)));
        end
        drain();
        for (int n = 0; n < 40; n++) begin
            take_bits(1, r);
            take_bits(3, word);
            take_bits(32, data);
            if (r[0]) begin
                take_bits(1, r);
                take_bits(3, off);
                sel = int'(off % 32'd5);
                take_bits(2, off);
                if (sel >= 2) off[0] = 1'b0;
                if (sel == 4) off[1] = 1'b0;
                core_op(r[0] ? MEM_WRITE : MEM_READ, sizes[sel],
                        32'h100 + (word << 2) + off, data, c);
            end else begin
                take_bits(1, r);
                host_op(r[0], 32'h100 + (word << 2), data);
            end
            drain();
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        mem_stage_valid = 1'b0;
        mem_addr        = '0;
        mem_wdata       = '0;
        mem_dir         = MEM_READ;
        mem_size        = SIZE_W;
        host_req_valid  = 1'b0;
        host_addr       = '0;
        host_wdata      = '0;
        host_write      = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        write_read_words();
        store_lanes();
        load_extend();
        contend_ports();
        loads_back_to_back();
        random_traffic();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- tb.f
hw/core_pkg.sv
hw/core_stage_mem.sv
hw/host_mem_port.sv
hw/dmem_arbiter.sv
hw/dmem_sram.sv
hw/mem_subsys_top.sv
sim/mem_subsys_checker.sv
sim/tb_mem_subsys.sv

//--- Makefile
# Verilator build and run for the data-memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
